// ==== flist.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/branch_predictor.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
testbench/imem_model.sv
testbench/tb_fetch.sv

// ==== rtl/branch_predictor.sv ====
////////////////////
// branch predictor
// direct mapped btb with a 2 bit saturating counter per entry,
// looked up by fetch pc, trained by execute
////////////////////

`timescale 1ns/1ns

`include "fetch_macros.svh"

module branch_predictor (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`XLEN-1:0]          pc,             // fetch pc
	input  fetch_pkg::branch_resolve_t resolve,       // update from execute
	output logic                      predict_taken,
	output logic [`XLEN-1:0]          predict_target
);

	// tag is whatever is left above index and byte offset
	localparam int TAG_W = `XLEN - `BTB_INDEX_W - 2;

	////////////////////
	// storage
	////////////////////

	logic [`BTB_ENTRIES-1:0] entry_valid;              // cleared by reset
	logic [TAG_W-1:0]        entry_tag    [`BTB_ENTRIES];
	logic [`XLEN-1:0]        entry_target [`BTB_ENTRIES];
	logic [1:0]              entry_count  [`BTB_ENTRIES]; // 2 and up predicts taken

	// lookup side
	logic [`BTB_INDEX_W-1:0] rd_index;
	logic [TAG_W-1:0]        rd_tag;
	logic                    rd_hit;

	// update side
	logic [`BTB_INDEX_W-1:0] wr_index;
	logic [TAG_W-1:0]        wr_tag;
	logic                    wr_hit;      // resolved branch already has an entry
	logic                    wr_allocate; // taken miss, claim the entry
	logic                    wr_update;   // train an existing entry
	logic [1:0]              wr_count;    // counter value to write back

	////////////////////
	// lookup
	////////////////////

	assign rd_index = pc[`BTB_INDEX_W+1:2];
	assign rd_tag   = pc[`XLEN-1:`BTB_INDEX_W+2];

	assign rd_hit = entry_valid[rd_index] && (entry_tag[rd_index] == rd_tag);

	// purely combinational so a same cycle update is not visible yet
	assign predict_taken  = rd_hit && entry_count[rd_index][1];
	assign predict_target = entry_target[rd_index]; // only meaningful with predict_taken

	////////////////////
	// update
	////////////////////

	assign wr_index = resolve.pc[`BTB_INDEX_W+1:2];
	assign wr_tag   = resolve.pc[`XLEN-1:`BTB_INDEX_W+2];

	assign wr_hit = entry_valid[wr_index] && (entry_tag[wr_index] == wr_tag);

	assign wr_allocate = resolve.branch && resolve.taken && !wr_hit;
	assign wr_update   = resolve.branch && wr_hit; // not taken miss does nothing

	// saturating counter step
	always_comb begin
		wr_count = entry_count[wr_index];
		if (wr_allocate) begin
			wr_count = 2'd2; // weakly taken
		end else if (resolve.taken) begin
			if (wr_count != 2'd3) begin
				wr_count = wr_count + 2'd1;
			end
		end else begin
			if (wr_count != 2'd0) begin
				wr_count = wr_count - 2'd1;
			end
		end
	end

	// allocation marks the entry valid
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			entry_valid <= '0;
		end else if (wr_allocate) begin
			entry_valid[wr_index] <= 1'b1;
		end
	end

	// counter, target and tag of the indexed entry
	always_ff @(posedge clock) begin
		if (wr_allocate || wr_update) begin
			entry_count[wr_index] <= wr_count;
			if (resolve.taken) begin
				entry_target[wr_index] <= resolve.target; // refresh target on every taken
			end
			if (wr_allocate) begin
				entry_tag[wr_index] <= wr_tag;
			end
		end
	end

endmodule

// ==== rtl/fetch_macros.svh ====
////////////////////
// fetch front end sizing
// bus widths, transaction tags and predictor geometry
////////////////////

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// datapath
`define XLEN        32 // every address and pc
`define MEM_DATA_W  64 // one aligned bus read
`define MEM_TAG_W   4  // transaction number, zero is none

// branch target buffer
`define BTB_ENTRIES 16
`define BTB_INDEX_W 4  // pc bits just above the byte offset

`endif

// ==== rtl/fetch_pkg.sv ====
////////////////////
// fetch front end types
// bus command, memory request and response, branch resolve
// and the packet handed to decode
////////////////////

`include "fetch_macros.svh"

package fetch_pkg;

	////////////////////
	// instruction memory bus
	////////////////////

	// fetch only ever drives none and load
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} mem_command_t;

	typedef struct packed {
		mem_command_t      command;
		logic [`XLEN-1:0]  address; // 8 byte aligned
	} imem_request_t;

	typedef struct packed {
		logic [`MEM_TAG_W-1:0]  response; // number accepted this cycle, 0 = busy
		logic [`MEM_TAG_W-1:0]  tag;      // number whose data is on the bus now
		logic [`MEM_DATA_W-1:0] data;
	} imem_response_t;

	////////////////////
	// pipeline side
	////////////////////

	// resolution from execute, valid for one cycle
	typedef struct packed {
		logic              branch;     // instruction in execute is a branch
		logic              taken;
		logic              mispredict; // single cycle pulse
		logic [`XLEN-1:0]  pc;         // pc of the branch itself
		logic [`XLEN-1:0]  target;     // correct next pc, taken or not
	} branch_resolve_t;

	// fetch to decode
	typedef struct packed {
		logic              valid;
		logic [31:0]       inst;
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  npc;            // pc + 4
		logic              predict_taken;
		logic [`XLEN-1:0]  predict_target;
	} fetch_packet_t;

endpackage

// ==== rtl/fetch_stage.sv ====
////////////////////
// instruction fetch stage
// keeps the pc, issues one tagged load at a time, waits for the
// matching tag and hands the selected word to decode
////////////////////

`timescale 1ns/1ns

`include "fetch_macros.svh"

module fetch_stage (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       enable,     // low = pipeline stalled
	input  logic                       mem_hazard, // shared port busy
	input  fetch_pkg::branch_resolve_t resolve,
	input  fetch_pkg::imem_response_t  imem_rsp,
	output fetch_pkg::imem_request_t   imem_req,
	output fetch_pkg::fetch_packet_t   packet
);

	// request FSM
	typedef enum logic {
		state_ready,    // free to issue a load
		state_mem_wait  // one load accepted, waiting for its tag
	} fetch_state_t;

	fetch_state_t state;
	fetch_state_t next_state;

	logic [`MEM_TAG_W-1:0] recorded;      // accepted transaction number, 0 = none
	logic [`MEM_TAG_W-1:0] next_recorded;

	logic [`XLEN-1:0] pc_reg;   // pc being fetched
	logic [`XLEN-1:0] pc_plus_4;
	logic [`XLEN-1:0] next_pc;

	logic pc_enable;   // stall lifted or redirect pending
	logic issue;       // bus_load goes out this cycle
	logic imem_ready;  // data for the recorded number is on the bus
	logic fetch_done;  // packet handed to decode this cycle

	logic             predict_taken;
	logic [`XLEN-1:0] predict_target;

	////////////////////
	// predictor
	////////////////////

	branch_predictor bp_i (
		.clock          (clock),
		.reset          (reset),
		.pc             (pc_reg),
		.resolve        (resolve),
		.predict_taken  (predict_taken),
		.predict_target (predict_target)
	);

	////////////////////
	// bus request
	////////////////////

	// a mispredict must get through a stall or it would be lost
	assign pc_enable = enable | resolve.mispredict;

	assign issue = (state == state_ready) && pc_enable && !mem_hazard;

	assign imem_req.command = issue ? fetch_pkg::bus_load : fetch_pkg::bus_none;
	assign imem_req.address = {pc_reg[`XLEN-1:3], 3'b000}; // aligned 64 bit read

	// tag match ends the fetch, number 0 never matches
	assign imem_ready = (recorded != '0) && (recorded == imem_rsp.tag);

	// data of a fetch being thrown away is not delivered
	assign fetch_done = imem_ready && !resolve.mispredict;

	always_comb begin
		next_state    = state;
		next_recorded = recorded;
		if (resolve.mispredict) begin
			// abandon whatever is pending, late data is ignored
			next_state    = state_ready;
			next_recorded = '0;
		end else begin
			case (state)
				state_ready: begin
					if (issue && (imem_rsp.response != '0)) begin // accepted
						next_state    = state_mem_wait;
						next_recorded = imem_rsp.response;
					end
					// refused: command repeats next cycle
				end
				state_mem_wait: begin
					if (imem_ready) begin
						next_state    = state_ready;
						next_recorded = '0;
					end
				end
				default: begin
					next_state    = state_ready;
					next_recorded = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state    <= state_ready;
			recorded <= '0;
		end else begin
			state    <= next_state;
			recorded <= next_recorded;
		end
	end

	////////////////////
	// next pc
	////////////////////

	assign pc_plus_4 = pc_reg + `XLEN'd4;

	// mispredict target, then predicted target, then fall through
	always_comb begin
		next_pc = pc_plus_4;
		if (resolve.mispredict) begin
			next_pc = resolve.target;
		end else if (predict_taken) begin
			next_pc = predict_target;
		end
	end

	// a packet taken while stalled does not advance, it is fetched again
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc_reg <= '0;
		end else if ((pc_enable && fetch_done) || resolve.mispredict) begin
			pc_reg <= next_pc;
		end
	end

	////////////////////
	// packet to decode
	////////////////////

	always_comb begin
		packet.valid          = fetch_done;
		packet.inst           = pc_reg[2] ? imem_rsp.data[`MEM_DATA_W-1:32]
		                                  : imem_rsp.data[31:0]; // bit 2 picks the half
		packet.pc             = pc_reg;
		packet.npc            = pc_plus_4;
		packet.predict_taken  = predict_taken;
		packet.predict_target = predict_target;
	end

endmodule

// ==== rtl/fetch_top.sv ====
////////////////////
// fetch front end top
// subsystem boundary for the rest of the pipeline
////////////////////

`timescale 1ns/1ns

module fetch_top (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       enable,     // pipeline stall, active low
	input  logic                       mem_hazard, // shared memory port in use
	input  fetch_pkg::branch_resolve_t resolve,    // from execute
	input  fetch_pkg::imem_response_t  imem_rsp,   // from instruction memory
	output fetch_pkg::imem_request_t   imem_req,   // to instruction memory
	output fetch_pkg::fetch_packet_t   packet      // to decode
);

	////////////////////
	// fetch stage
	////////////////////

	// predictor lives inside the stage, it only sees the fetch pc
	fetch_stage fetch_i (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable),
		.mem_hazard (mem_hazard),
		.resolve    (resolve),
		.imem_rsp   (imem_rsp),
		.imem_req   (imem_req),
		.packet     (packet)
	);

endmodule

// ==== testbench/imem_model.sv ====
////////////////////
// instruction memory model
// tagged loads with random busy answers
// and 1 to 4 cycles of latency
////////////////////

`timescale 1ns/1ns

`include "fetch_macros.svh"

module imem_model (
	input  logic                      clock,
	input  logic                      reset,
	input  fetch_pkg::imem_request_t  req,
	output fetch_pkg::imem_response_t rsp
);

	localparam logic [31:0] FILL_KEY  = 32'hA5A5_0000; // each word is its address xor this
	localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;

	logic [31:0]            lfsr_state = 32'd74252;
	logic                   accept_now = 1'b0; // answer for the current cycle
	logic [`MEM_TAG_W-1:0]  next_num   = 'd1;  // never zero
	logic                   pending    = 1'b0; // one accepted load in flight
	logic [`MEM_TAG_W-1:0]  pend_num   = '0;
	logic [`XLEN-1:0]       pend_addr  = '0;
	int unsigned            wait_left  = 0;
	logic [`MEM_TAG_W-1:0]  tag_out    = '0;
	logic [`MEM_DATA_W-1:0] data_out   = '0;

	// sampled mid cycle, away from both edges
	logic                   took       = 1'b0;
	logic [`XLEN-1:0]       took_addr  = '0;
	logic                   reset_seen = 1'b1;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] shifted;
		shifted = state >> 1;
		if (state[0]) begin
			shifted = shifted ^ LFSR_TAPS;
		end
		return shifted;
	endfunction

	// one lfsr step per bit
	function automatic logic take_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	assign rsp.response = (req.command == fetch_pkg::bus_load && accept_now) ? next_num : '0;
	assign rsp.tag      = tag_out;
	assign rsp.data     = data_out;

	always @(negedge clock) begin
		took       = (req.command == fetch_pkg::bus_load) && (rsp.response != '0);
		took_addr  = req.address;
		reset_seen = reset;
	end

	always @(posedge clock) begin : bus_step
		logic [1:0] pick;
		#2;
		tag_out  = '0; // no tag unless data goes out
		data_out = '0;
		if (reset_seen) begin
			pending    = 1'b0;
			accept_now = 1'b0;
		end else begin
			if (pending) begin
				if (wait_left <= 1) begin
					tag_out  = pend_num;
					data_out = {(pend_addr + 32'd4) ^ FILL_KEY, pend_addr ^ FILL_KEY};
					pending  = 1'b0;
				end else begin
					wait_left = wait_left - 1;
				end
			end
			if (took) begin // accepted in the cycle just ended
				pending   = 1'b1;
				pend_num  = next_num;
				pend_addr = took_addr;
				pick[0]   = take_bit();
				pick[1]   = take_bit();
				wait_left = pick + 1;
				next_num  = (next_num == '1) ? 'd1 : next_num + 'd1;
			end
			// busy while a load is out, otherwise one time in four
			if (pending) begin
				accept_now = 1'b0;
			end else begin
				pick[0]    = take_bit();
				pick[1]    = take_bit();
				accept_now = (pick != 2'b11);
			end
		end
	end

endmodule

// ==== testbench/tb_fetch.sv ====
////////////////////
// fetch front end testbench
// scenario table run against a reference pc and btb model
////////////////////

`timescale 1ns/1ns

`include "fetch_macros.svh"

module tb_fetch;

	localparam logic [31:0] FILL_KEY = 32'hA5A5_0000; // memory word is address xor key
	localparam int          ROWS     = 9;

	typedef struct packed {
		logic [7:0]       fetches;    // packets that advance the pc
		logic [7:0]       stall;      // enable low on set bits of cycle mod 8
		logic [7:0]       hazard;     // mem_hazard on set bits
		logic             has_branch;
		logic [7:0]       after;      // fetches done before the resolve
		logic [7:0]       delay;      // then this many more cycles
		logic             taken;
		logic             mispredict;
		logic [`XLEN-1:0] pc;         // branch pc
		logic [`XLEN-1:0] target;     // correct next pc
	} scenario_t;

	logic                       clock;
	logic                       reset;
	logic                       enable;
	logic                       mem_hazard;
	fetch_pkg::branch_resolve_t resolve;
	fetch_pkg::imem_response_t  imem_rsp;
	fetch_pkg::imem_request_t   imem_req;
	fetch_pkg::fetch_packet_t   packet;

	scenario_t table_rows [ROWS];

	// reference pc and btb
	logic [`XLEN-1:0] model_pc;
	logic             model_valid  [`BTB_ENTRIES];
	logic [`XLEN-1:0] model_owner  [`BTB_ENTRIES]; // pc of the branch held
	logic [`XLEN-1:0] model_target [`BTB_ENTRIES];
	int               model_count  [`BTB_ENTRIES];

	int checks      = 0;
	int errors      = 0;
	int cycle_count = 0;
	int cycle_limit = 100;

	fetch_top dut_i (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable),
		.mem_hazard (mem_hazard),
		.resolve    (resolve),
		.imem_rsp   (imem_rsp),
		.imem_req   (imem_req),
		.packet     (packet)
	);

	imem_model imem_i (
		.clock (clock),
		.reset (reset),
		.req   (imem_req),
		.rsp   (imem_rsp)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles with fetches still outstanding", cycle_count);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////
	// reference model
	////////////////////

	function automatic int btb_index(input logic [`XLEN-1:0] pc);
		return int'(pc[`BTB_INDEX_W+1:2]);
	endfunction

	// hit with a counter of 2 or more
	function automatic logic btb_predicts(input logic [`XLEN-1:0] pc);
		int idx;
		idx = btb_index(pc);
		return model_valid[idx] && (model_count[idx] >= 2)
			&& (model_owner[idx][`XLEN-1:`BTB_INDEX_W+2] == pc[`XLEN-1:`BTB_INDEX_W+2]);
	endfunction

	task automatic btb_train(input fetch_pkg::branch_resolve_t r);
		int   idx;
		logic hit;
		idx = btb_index(r.pc);
		hit = model_valid[idx]
			&& (model_owner[idx][`XLEN-1:`BTB_INDEX_W+2] == r.pc[`XLEN-1:`BTB_INDEX_W+2]);
		if (r.branch && hit) begin
			if (r.taken) begin
				model_count[idx]  = (model_count[idx] == 3) ? 3 : model_count[idx] + 1;
				model_target[idx] = r.target;
			end else if (model_count[idx] > 0) begin
				model_count[idx] = model_count[idx] - 1;
			end
		end else if (r.branch && r.taken) begin // taken miss allocates weakly taken
			model_valid[idx]  = 1'b1;
			model_owner[idx]  = r.pc;
			model_target[idx] = r.target;
			model_count[idx]  = 2;
		end
	endtask

	task automatic check_value(input string name, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	// outputs sampled at the falling edge and the model stepped to the next rising edge
	task automatic check_cycle(output logic advanced);
		logic             predicted;
		logic [`XLEN-1:0] expect_target;
		advanced      = 1'b0;
		predicted     = btb_predicts(model_pc);
		expect_target = model_target[btb_index(model_pc)];
		if ((!enable && !resolve.mispredict) || mem_hazard) begin
			check_value("imem_req.command", imem_req.command, fetch_pkg::bus_none);
		end
		if (imem_req.command == fetch_pkg::bus_load) begin
			check_value("imem_req.address", imem_req.address, {model_pc[`XLEN-1:3], 3'b000});
		end else begin
			check_value("imem_req.command", imem_req.command, fetch_pkg::bus_none);
		end
		if (resolve.mispredict) begin
			check_value("packet.valid", packet.valid, 1'b0); // abandoned data never shows
			model_pc = resolve.target;
		end else if (packet.valid) begin
			check_value("packet.pc", packet.pc, model_pc);
			check_value("packet.inst", packet.inst, model_pc ^ FILL_KEY);
			check_value("packet.npc", packet.npc, model_pc + 32'd4);
			check_value("packet.predict_taken", packet.predict_taken, predicted);
			if (predicted) begin
				check_value("packet.predict_target", packet.predict_target, expect_target);
			end
			if (enable) begin // stalled packets come again after a refetch
				advanced = 1'b1;
				model_pc = predicted ? expect_target : model_pc + 32'd4;
			end
		end
		btb_train(resolve); // lookup above saw the old entry
	endtask

	////////////////////
	// scenario rows
	////////////////////

	task automatic run_row(input int r);
		scenario_t row;
		int        fetched;
		int        cycle;
		int        hold;
		int        errors_before;
		logic      sent;
		logic      advanced;
		row           = table_rows[r];
		fetched       = 0;
		cycle         = 0;
		hold          = 0;
		errors_before = errors;
		sent          = 1'b0;
		while (fetched < row.fetches) begin
			@(posedge clock);
			#2;
			enable     = !row.stall[cycle % 8];
			mem_hazard = row.hazard[cycle % 8];
			resolve    = '0;
			if (row.has_branch && !sent && fetched >= row.after) begin
				if (hold == row.delay) begin
					resolve.branch     = 1'b1;
					resolve.taken      = row.taken;
					resolve.mispredict = row.mispredict;
					resolve.pc         = row.pc;
					resolve.target     = row.target;
					sent               = 1'b1;
				end else begin
					hold++;
				end
			end
			@(negedge clock);
			check_cycle(advanced);
			if (advanced) begin
				fetched++;
			end
			cycle++;
		end
		$display("row %0d done with %0d fetches in %0d cycles and %0d errors",
			r, fetched, cycle, errors - errors_before);
	endtask

	initial begin
		reset      = 1'b1;
		enable     = 1'b0;
		mem_hazard = 1'b0;
		resolve    = '0;
		model_pc   = '0;
		foreach (model_valid[i]) begin
			model_valid[i] = 1'b0;
		end
		// fetches stall hazard branch after delay taken mispredict pc target
		table_rows[0] = '{8'd8,  8'h00, 8'h00, 1'b0, 8'd0, 8'd0, 1'b0, 1'b0, 32'h0,   32'h0};
		table_rows[1] = '{8'd10, 8'h24, 8'h41, 1'b0, 8'd0, 8'd0, 1'b0, 1'b0, 32'h0,   32'h0};
		table_rows[2] = '{8'd4,  8'h00, 8'h00, 1'b1, 8'd0, 8'd0, 1'b1, 1'b0, 32'h50,  32'h100};
		table_rows[3] = '{8'd5,  8'h00, 8'h00, 1'b1, 8'd1, 8'd2, 1'b1, 1'b1, 32'h108, 32'h48};
		table_rows[4] = '{8'd3,  8'h00, 8'h00, 1'b1, 8'd0, 8'd0, 1'b1, 1'b0, 32'h50,  32'h100};
		table_rows[5] = '{8'd2,  8'h00, 8'h00, 1'b1, 8'd0, 8'd0, 1'b0, 1'b0, 32'h50,  32'h54};
		table_rows[6] = '{8'd2,  8'h00, 8'h00, 1'b1, 8'd0, 8'd0, 1'b0, 1'b1, 32'h50,  32'h54};
		table_rows[7] = '{8'd4,  8'h00, 8'h00, 1'b1, 8'd0, 8'd0, 1'b1, 1'b1, 32'h60,  32'h48};
		table_rows[8] = '{8'd6,  8'hF0, 8'h0C, 1'b0, 8'd0, 8'd0, 1'b0, 1'b0, 32'h0,   32'h0};
		foreach (table_rows[i]) begin
			cycle_limit = cycle_limit + table_rows[i].fetches * 12;
		end
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
		for (int r = 0; r < ROWS; r++) begin
			run_row(r);
		end
		$display("%0d checks with %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
